// File: rtl/noc_config_pkg.sv
`default_nettype none

package noc_config_pkg;

  // ************************************************************
  // router sizes.
  // ************************************************************

  // input ports feeding this output port.
  localparam int NOC_PORTS = 5;

  // virtual channels per link.
  localparam int NOC_CHANNELS = 2;

  // flit payload width.
  localparam int NOC_DATA_WIDTH = 32;

  // flits held by each input buffer.
  localparam int NOC_FIFO_DEPTH = 4;

  // ************************************************************
  // derived widths.
  // ************************************************************

  // bits needed to name one virtual channel.
  localparam int NOC_VC_WIDTH = (NOC_CHANNELS > 1) ? $clog2(NOC_CHANNELS) : 1;

endpackage

`default_nettype wire

// File: rtl/noc_flit_pkg.sv
`default_nettype none

package noc_flit_pkg;

  // virtual channel index.
  typedef logic [noc_config_pkg::NOC_VC_WIDTH-1:0] noc_vc_t;

  // ************************************************************
  // flit as it travels over a link.
  // ************************************************************
  typedef struct packed {
    logic                                     head;
    logic                                     tail;
    noc_vc_t                                  vc;
    logic [noc_config_pkg::NOC_DATA_WIDTH-1:0] data;
  } noc_flit_t;

  // control bits of the flit at a buffer head.
  typedef struct packed {
    logic    valid;
    logic    head;
    logic    tail;
    noc_vc_t vc;
  } noc_port_status_t;

  // one-hot input select plus the channel being served.
  typedef struct packed {
    logic [noc_config_pkg::NOC_PORTS-1:0] port;
    noc_vc_t                              vc;
  } noc_port_grant_t;

endpackage

`default_nettype wire

// File: rtl/noc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module noc_fifo #(
  parameter int DEPTH = noc_config_pkg::NOC_FIFO_DEPTH
) (
  input  logic                            clk,
  input  logic                            i_arst_n,
  input  logic                            i_push_valid,
  output logic                            o_push_ready,
  input  noc_flit_pkg::noc_flit_t         i_push_flit,
  output logic                            o_pop_valid,
  input  logic                            i_pop_ready,
  output noc_flit_pkg::noc_flit_t         o_pop_flit,
  output noc_flit_pkg::noc_port_status_t  o_status
);
  import noc_flit_pkg::*;

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  noc_flit_t              mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   push;
  logic                   pop;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // ready only looks at the fill level.
  assign o_push_ready = (count != COUNT_WIDTH'(DEPTH));
  assign o_pop_valid  = (count != '0);
  assign push         = i_push_valid && o_push_ready;
  assign pop          = o_pop_valid && i_pop_ready;
  assign o_pop_flit   = mem[rd_ptr];

  // head summary for the controller.
  assign o_status.valid = o_pop_valid;
  assign o_status.head  = mem[rd_ptr].head;
  assign o_status.tail  = mem[rd_ptr].tail;
  assign o_status.vc    = mem[rd_ptr].vc;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_push_flit;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/noc_round_robin_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module noc_round_robin_arbiter #(
  parameter int REQUESTS = 2
) (
  input  logic                clk,
  input  logic                i_arst_n,
  input  logic [REQUESTS-1:0] i_request,
  input  logic                i_free,
  output logic [REQUESTS-1:0] o_grant
);
  localparam int IDX_WIDTH = (REQUESTS > 1) ? $clog2(REQUESTS) : 1;

  logic [REQUESTS-1:0]  grant_q;
  logic [REQUESTS-1:0]  pick_grant;
  logic [IDX_WIDTH-1:0] pick_index;
  logic [IDX_WIDTH-1:0] last_index;
  logic                 busy;

  assign busy = |grant_q;

  // ************************************************************
  // rotating priority search.
  // ************************************************************

  // walk from the far end so the nearest requester after the
  // last winner is the one left standing.
  always_comb begin
    pick_grant = '0;
    pick_index = last_index;
    for (int offset = REQUESTS; offset >= 1; offset--) begin
      if (i_request[(int'(last_index) + offset) % REQUESTS]) begin
        pick_grant = '0;
        pick_grant[(int'(last_index) + offset) % REQUESTS] = 1'b1;
        pick_index = IDX_WIDTH'((int'(last_index) + offset) % REQUESTS);
      end
    end
  end

  // ************************************************************
  // grant hold.
  // ************************************************************

  // a packet that finishes in its first cycle leaves nothing held.
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      grant_q    <= '0;
      last_index <= IDX_WIDTH'(REQUESTS - 1);
    end else if (busy) begin
      if (i_free) begin
        grant_q <= '0;
      end
    end else if (|pick_grant) begin
      last_index <= pick_index;
      if (i_free) begin
        grant_q <= '0;
      end else begin
        grant_q <= pick_grant;
      end
    end
  end

  // live pick while idle, held grant afterwards.
  assign o_grant = busy ? grant_q : pick_grant;

endmodule

`default_nettype wire

// File: rtl/noc_port_controller.sv
`timescale 1ns/1ps
`default_nettype none

module noc_port_controller (
  input  logic                                      clk,
  input  logic                                      i_arst_n,
  input  noc_flit_pkg::noc_port_status_t            i_port_status [noc_config_pkg::NOC_PORTS],
  input  logic [noc_config_pkg::NOC_CHANNELS-1:0]   i_vc_available,
  input  logic                                      i_packet_done,
  output noc_flit_pkg::noc_port_grant_t             o_port_grant
);
  import noc_config_pkg::*;
  import noc_flit_pkg::*;

  logic [NOC_PORTS-1:0]    port_request [NOC_CHANNELS];
  logic [NOC_PORTS-1:0]    port_grant [NOC_CHANNELS];
  logic [NOC_CHANNELS-1:0] port_free;
  logic [NOC_CHANNELS-1:0] vc_request;
  logic [NOC_CHANNELS-1:0] vc_grant;

  // ************************************************************
  // port arbitration.
  // ************************************************************

  // only a buffered head flit may open a packet on its channel.
  always_comb begin
    for (int v = 0; v < NOC_CHANNELS; v++) begin
      for (int p = 0; p < NOC_PORTS; p++) begin
        port_request[v][p] = i_port_status[p].valid &&
                             i_port_status[p].head &&
                             (i_port_status[p].vc == noc_vc_t'(v));
      end
    end
  end

  for (genvar v = 0; v < NOC_CHANNELS; v++) begin : g_port_arbitration
    // this channel's winner is released only when its tail leaves.
    assign port_free[v] = i_packet_done && vc_grant[v];

    noc_round_robin_arbiter #(
      .REQUESTS (NOC_PORTS)
    ) u_port_arbiter (
      .clk       (clk),
      .i_arst_n  (i_arst_n),
      .i_request (port_request[v]),
      .i_free    (port_free[v]),
      .o_grant   (port_grant[v])
    );

    // downstream space matters only at packet start.
    assign vc_request[v] = (|port_grant[v]) && i_vc_available[v];
  end

  // ************************************************************
  // vc arbitration.
  // ************************************************************
  noc_round_robin_arbiter #(
    .REQUESTS (NOC_CHANNELS)
  ) u_vc_arbiter (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_request (vc_request),
    .i_free    (i_packet_done),
    .o_grant   (vc_grant)
  );

  // winning channel's port grant goes to the switch.
  always_comb begin
    o_port_grant = '0;
    for (int v = 0; v < NOC_CHANNELS; v++) begin
      if (vc_grant[v]) begin
        o_port_grant.port = port_grant[v];
        o_port_grant.vc   = noc_vc_t'(v);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/noc_output_switch.sv
`timescale 1ns/1ps
`default_nettype none

module noc_output_switch (
  input  noc_flit_pkg::noc_port_grant_t         i_port_grant,
  input  logic [noc_config_pkg::NOC_PORTS-1:0]  i_head_valid,
  input  noc_flit_pkg::noc_flit_t               i_head_flit [noc_config_pkg::NOC_PORTS],
  output logic [noc_config_pkg::NOC_PORTS-1:0]  o_pop,
  output logic                                  o_out_valid,
  input  logic                                  i_out_ready,
  output noc_flit_pkg::noc_flit_t               o_out_flit,
  output logic                                  o_packet_done
);
  import noc_config_pkg::*;
  import noc_flit_pkg::*;

  noc_flit_t selected_flit;
  logic      transfer;

  // ************************************************************
  // one-hot flit select.
  // ************************************************************
  always_comb begin
    selected_flit = '0;
    for (int p = 0; p < NOC_PORTS; p++) begin
      if (i_port_grant.port[p]) begin
        selected_flit = i_head_flit[p];
      end
    end
  end

  assign o_out_valid = |(i_port_grant.port & i_head_valid);

  // output carries the channel in service.
  always_comb begin
    o_out_flit    = selected_flit;
    o_out_flit.vc = i_port_grant.vc;
  end

  // ************************************************************
  // consumer side.
  // ************************************************************
  assign transfer      = o_out_valid && i_out_ready;
  assign o_pop         = transfer ? i_port_grant.port : '0;
  assign o_packet_done = transfer && o_out_flit.tail;

endmodule

`default_nettype wire

// File: rtl/noc_output_port.sv
`timescale 1ns/1ps
`default_nettype none

module noc_output_port (
  input  logic                                      clk,
  input  logic                                      i_arst_n,
  input  logic [noc_config_pkg::NOC_PORTS-1:0]      i_in_valid,
  output logic [noc_config_pkg::NOC_PORTS-1:0]      o_in_ready,
  input  noc_flit_pkg::noc_flit_t                   i_in_flit [noc_config_pkg::NOC_PORTS],
  input  logic [noc_config_pkg::NOC_CHANNELS-1:0]   i_vc_available,
  output logic                                      o_out_valid,
  input  logic                                      i_out_ready,
  output noc_flit_pkg::noc_flit_t                   o_out_flit
);
  import noc_config_pkg::*;
  import noc_flit_pkg::*;

  noc_port_status_t     port_status [NOC_PORTS];
  noc_flit_t            head_flit [NOC_PORTS];
  logic [NOC_PORTS-1:0] head_valid;
  logic [NOC_PORTS-1:0] pop;
  noc_port_grant_t      port_grant;
  logic                 packet_done;

  // ************************************************************
  // input buffers.
  // ************************************************************
  for (genvar p = 0; p < NOC_PORTS; p++) begin : g_input_buffer
    noc_fifo #(
      .DEPTH (NOC_FIFO_DEPTH)
    ) u_fifo (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_push_valid (i_in_valid[p]),
      .o_push_ready (o_in_ready[p]),
      .i_push_flit  (i_in_flit[p]),
      .o_pop_valid  (head_valid[p]),
      .i_pop_ready  (pop[p]),
      .o_pop_flit   (head_flit[p]),
      .o_status     (port_status[p])
    );
  end

  // ************************************************************
  // arbitration and switch.
  // ************************************************************
  noc_port_controller u_port_controller (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_port_status  (port_status),
    .i_vc_available (i_vc_available),
    .i_packet_done  (packet_done),
    .o_port_grant   (port_grant)
  );

  noc_output_switch u_output_switch (
    .i_port_grant  (port_grant),
    .i_head_valid  (head_valid),
    .i_head_flit   (head_flit),
    .o_pop         (pop),
    .o_out_valid   (o_out_valid),
    .i_out_ready   (i_out_ready),
    .o_out_flit    (o_out_flit),
    .o_packet_done (packet_done)
  );

endmodule

`default_nettype wire

// File: tests/tb_noc_output_port.sv
`timescale 1ns/1ps
`default_nettype none

module tb_noc_output_port;
  import noc_config_pkg::*;
  import noc_flit_pkg::*;

  localparam int PACKETS_PER_PORT = 8;
  localparam int MAX_FLITS        = 4;
  localparam int TIMEOUT_CYCLES   = NOC_PORTS * PACKETS_PER_PORT * MAX_FLITS * 50;

  logic                    clk;
  logic                    arst_n;
  logic [NOC_PORTS-1:0]    in_valid;
  logic [NOC_PORTS-1:0]    in_ready;
  noc_flit_t               in_flit [NOC_PORTS];
  logic [NOC_CHANNELS-1:0] vc_available;
  logic                    out_valid;
  logic                    out_ready;
  noc_flit_t               out_flit;

  // stimulus state per input.
  logic [15:0] lfsr_state;
  int          pkt_num [NOC_PORTS];
  int          flit_idx [NOC_PORTS];
  int          pkt_len [NOC_PORTS];
  noc_vc_t     pkt_vc [NOC_PORTS];

  // scoreboard state.
  noc_flit_t   expected [NOC_PORTS][$];
  int          served [NOC_PORTS][NOC_PORTS];
  logic        in_packet;
  int          cur_port;
  noc_vc_t     cur_vc;
  logic        stall_q;
  noc_flit_t   stall_flit_q;
  logic        accepted_any;
  int          cycle_count;

  noc_output_port DUT (
    .clk            (clk),
    .i_arst_n       (arst_n),
    .i_in_valid     (in_valid),
    .o_in_ready     (in_ready),
    .i_in_flit      (in_flit),
    .i_vc_available (vc_available),
    .o_out_valid    (out_valid),
    .i_out_ready    (out_ready),
    .o_out_flit     (out_flit)
  );

  always #5 clk = ~clk;

  // fibonacci lfsr with taps 16 14 13 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  function automatic int take_bits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
    return value;
  endfunction

  // data bytes are port, packet, flit index and packet length.
  function automatic noc_flit_t build_flit(input int port, input int pkt, input int idx,
                                           input int len, input noc_vc_t vc);
    noc_flit_t flit;
    flit.head = (idx == 0);
    flit.tail = (idx == len - 1);
    flit.vc   = vc;
    flit.data = {8'(port), 8'(pkt), 8'(idx), 8'(len)};
    return flit;
  endfunction

  function automatic logic run_complete();
    for (int p = 0; p < NOC_PORTS; p++) begin
      if (pkt_num[p] < PACKETS_PER_PORT || expected[p].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp_value,
                                 input logic [63:0] act_value);
    report_failure($sformatf("MISMATCH %s: expected 0x%h, got 0x%h", name, exp_value,
                             act_value));
  endtask

  // ************************************************************
  // stimulus.
  // ************************************************************
  always @(posedge clk) begin
    int avail_a;
    int avail_b;
    if (arst_n) begin
      out_ready <= (take_bits(2) != 0);
      avail_a = take_bits(NOC_CHANNELS);
      avail_b = take_bits(NOC_CHANNELS);
      vc_available <= NOC_CHANNELS'(avail_a | avail_b);
      for (int p = 0; p < NOC_PORTS; p++) begin
        if (in_valid[p] && in_ready[p]) begin
          flit_idx[p] = flit_idx[p] + 1;
          if (flit_idx[p] == pkt_len[p]) begin
            pkt_num[p]  = pkt_num[p] + 1;
            flit_idx[p] = 0;
            pkt_len[p]  = 1 + take_bits(2);
            pkt_vc[p]   = noc_vc_t'(take_bits(NOC_VC_WIDTH));
          end
        end
        // a waiting flit is held until it is taken.
        if (pkt_num[p] >= PACKETS_PER_PORT) begin
          in_valid[p] <= 1'b0;
        end else if (!in_valid[p] || in_ready[p]) begin
          in_valid[p] <= (take_bits(2) != 0);
          in_flit[p]  <= build_flit(p, pkt_num[p], flit_idx[p], pkt_len[p], pkt_vc[p]);
        end
      end
    end
  end

  // ************************************************************
  // scoreboard.
  // ************************************************************
  always @(posedge clk) begin
    int   src;
    logic waiting [NOC_PORTS];
    if (arst_n) begin
      for (int p = 0; p < NOC_PORTS; p++) begin
        // queue length equals the flits still held in that buffer.
        assert (in_ready[p] == (expected[p].size() < NOC_FIFO_DEPTH))
          else report_mismatch($sformatf("o_in_ready[%0d]", p),
                               64'(expected[p].size() < NOC_FIFO_DEPTH),
                               64'(in_ready[p]));
        waiting[p] = (expected[p].size() != 0) && expected[p][0].head;
        if (!waiting[p]) begin
          for (int q = 0; q < NOC_PORTS; q++) begin
            served[p][q] = 0;
          end
        end
      end
      if (out_valid && out_ready) begin
        src = int'(out_flit.data[31:24]);
        assert (src < NOC_PORTS && expected[src].size() != 0)
          else report_failure($sformatf("output flit 0x%h matches no pending input flit",
                                        out_flit));
        if (src < NOC_PORTS && expected[src].size() != 0) begin
          assert (out_flit == expected[src][0])
            else report_mismatch("o_out_flit", 64'(expected[src][0]), 64'(out_flit));
          void'(expected[src].pop_front());
          // a head that leaves ends that input's wait.
          if (out_flit.head) begin
            for (int q = 0; q < NOC_PORTS; q++) begin
              served[src][q] = 0;
            end
          end
          if (in_packet) begin
            assert (!out_flit.head && src == cur_port && out_flit.vc == cur_vc)
              else report_failure($sformatf("packet of input %0d interleaved with input %0d",
                                            cur_port, src));
          end else begin
            assert (out_flit.head)
              else report_failure("a body flit left without its head flit before it");
          end
          in_packet = !out_flit.tail;
          cur_port  = src;
          cur_vc    = out_flit.vc;
          // a finished packet counts against every input still waiting on that vc.
          if (out_flit.tail) begin
            for (int p = 0; p < NOC_PORTS; p++) begin
              if (p != src && waiting[p] && expected[p][0].vc == out_flit.vc) begin
                served[p][src] = served[p][src] + 1;
                assert (served[p][src] <= 1)
                  else report_failure($sformatf("input %0d finished two packets while %0d waited",
                                                src, p));
              end
            end
          end
        end
      end
      for (int p = 0; p < NOC_PORTS; p++) begin
        if (in_valid[p] && in_ready[p]) begin
          expected[p].push_back(in_flit[p]);
          accepted_any <= 1'b1;
        end
      end
      stall_q      <= out_valid && !out_ready;
      stall_flit_q <= out_flit;
    end
  end

  // ************************************************************
  // output protocol.
  // ************************************************************
  stall_keeps_valid: assert property (@(posedge clk) disable iff (!arst_n)
    stall_q |-> out_valid)
    else report_failure("o_out_valid dropped while the output was stalled");

  stall_keeps_flit: assert property (@(posedge clk) disable iff (!arst_n)
    (stall_q && out_valid) |-> (out_flit == stall_flit_q))
    else report_mismatch("o_out_flit", 64'($sampled(stall_flit_q)), 64'($sampled(out_flit)));

  head_needs_vc: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && out_flit.head && !stall_q) |-> vc_available[out_flit.vc])
    else report_failure("a head flit started on a virtual channel that was not available");

  quiet_after_reset: assert property (@(posedge clk)
    !accepted_any |-> !out_valid)
    else report_failure("o_out_valid rose before any flit was accepted");

  initial begin
    lfsr_state   = 16'd61459;
    clk          = 1'b0;
    arst_n       <= 1'b0;
    in_valid     <= '0;
    out_ready    <= 1'b0;
    vc_available <= '0;
    stall_q      <= 1'b0;
    stall_flit_q <= '0;
    accepted_any <= 1'b0;
    in_packet    = 1'b0;
    cur_port     = 0;
    cur_vc       = '0;
    cycle_count  = 0;
    for (int p = 0; p < NOC_PORTS; p++) begin
      in_flit[p]  <= '0;
      pkt_num[p]  = 0;
      flit_idx[p] = 0;
      pkt_len[p]  = 1 + take_bits(2);
      pkt_vc[p]   = noc_vc_t'(take_bits(NOC_VC_WIDTH));
      for (int q = 0; q < NOC_PORTS; q++) begin
        served[p][q] = 0;
      end
    end
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    while (!run_complete() && cycle_count < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycle_count = cycle_count + 1;
    end
    if (run_complete()) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      report_failure($sformatf("timeout with traffic still pending after %0d cycles",
                               cycle_count));
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
rtl/noc_config_pkg.sv
rtl/noc_flit_pkg.sv
rtl/noc_fifo.sv
rtl/noc_round_robin_arbiter.sv
rtl/noc_port_controller.sv
rtl/noc_output_switch.sv
rtl/noc_output_port.sv
tests/tb_noc_output_port.sv

// File: run_sim.sh
#!/bin/sh
# builds the output port testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
top=tb_noc_output_port

verilator --binary --assert --timing -Wno-fatal \
  --top-module "$top" --Mdir "$build_dir" -f verilog.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$build_dir/V$top" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Simulation finished: FAIL" "$log_file"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

if ! grep -q "Simulation finished: PASS" "$log_file"; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
exit 0
